/* project.f */
+incdir+sim
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/decode_if.sv
verilog/decoder.sv
verilog/alu.sv
verilog/regfile.sv
verilog/core_ctrl.sv
verilog/rv_core_top.sv
sim/tb_rv_core.sv

/* sim/tb_program.svh */
// ========================================
// Program image, loaded from address 0
// ========================================
localparam int PROG_LEN  = 49;
localparam int STORE_CNT = 18;

localparam core_pkg::word_t OPND_A     = 32'h0000_0123;   // x1
localparam core_pkg::word_t OPND_B     = 32'hFFFF_FFF9;   // x2, -7
localparam core_pkg::word_t PRELOAD    = 32'h1357_9BD0;   // Word at 0x100
localparam core_pkg::word_t LOAD_ADDR  = 32'h0000_0100;
localparam core_pkg::word_t STORE_BASE = 32'h0000_0200;   // x10, stores step by 4

core_pkg::word_t program_image [PROG_LEN] = '{
    32'h12300093,   // 00 addi x1, x0, 0x123
    32'hFF900113,   // 04 addi x2, x0, -7
    32'h20000513,   // 08 addi x10, x0, 0x200
    32'h00152023,   // 0C sw   x1, 0(x10)
    32'h002081B3,   // 10 add  x3, x1, x2
    32'h00352223,   // 14 sw   x3, 4(x10)
    32'h402081B3,   // 18 sub  x3, x1, x2
    32'h00352423,   // 1C sw   x3, 8(x10)
    32'h0020F1B3,   // 20 and  x3, x1, x2
    32'h00352623,   // 24 sw   x3, 12(x10)
    32'h0020E1B3,   // 28 or   x3, x1, x2
    32'h00352823,   // 2C sw   x3, 16(x10)
    32'h0020C1B3,   // 30 xor  x3, x1, x2
    32'h00352A23,   // 34 sw   x3, 20(x10)
    32'h001121B3,   // 38 slt  x3, x2, x1
    32'h00352C23,   // 3C sw   x3, 24(x10)
    32'h001131B3,   // 40 sltu x3, x2, x1
    32'h00352E23,   // 44 sw   x3, 28(x10)
    32'h00400213,   // 48 addi x4, x0, 4
    32'h004091B3,   // 4C sll  x3, x1, x4
    32'h02352023,   // 50 sw   x3, 32(x10)
    32'h004151B3,   // 54 srl  x3, x2, x4
    32'h02352223,   // 58 sw   x3, 36(x10)
    32'h404151B3,   // 5C sra  x3, x2, x4
    32'h02352423,   // 60 sw   x3, 40(x10)
    32'hABCDE1B7,   // 64 lui  x3, 0xABCDE
    32'h02352623,   // 68 sw   x3, 44(x10)
    32'h10002283,   // 6C lw   x5, 0x100(x0)
    32'h05528293,   // 70 addi x5, x5, 0x55
    32'h02552823,   // 74 sw   x5, 48(x10)
    32'h00100313,   // 78 addi x6, x0, 1
    32'h00630463,   // 7C beq  x6, x6, +8   taken
    32'h7FF00313,   // 80 addi x6, x0, 0x7FF   wrong path
    32'h02652A23,   // 84 sw   x6, 52(x10)
    32'h00631463,   // 88 bne  x6, x6, +8   not taken
    32'h00200313,   // 8C addi x6, x0, 2
    32'h02652C23,   // 90 sw   x6, 56(x10)
    32'h00C003EF,   // 94 jal  x7, +12
    32'h3FF00313,   // 98 addi x6, x0, 0x3FF   skipped
    32'h33300393,   // 9C addi x7, x0, 0x333   skipped
    32'h02752E23,   // A0 sw   x7, 60(x10)
    32'h0B100413,   // A4 addi x8, x0, 0xB1
    32'h004404E7,   // A8 jalr x9, 4(x8)   target 0xB5, bit 0 cleared
    32'h11100493,   // AC addi x9, x0, 0x111   skipped
    32'h22200493,   // B0 addi x9, x0, 0x222   skipped
    32'h04952023,   // B4 sw   x9, 64(x10)
    32'h05A00013,   // B8 addi x0, x0, 0x5A
    32'h04052223,   // BC sw   x0, 68(x10)
    32'h0000006F    // C0 jal  x0, 0   spin
};

// Expected store data, address is STORE_BASE + 4 * index
core_pkg::word_t expected_data [STORE_CNT] = '{
    OPND_A,                                 // Plain ADDI result
    OPND_A + OPND_B,
    OPND_A - OPND_B,
    OPND_A & OPND_B,
    OPND_A | OPND_B,
    OPND_A ^ OPND_B,
    32'd1,                                  // -7 < 0x123 signed
    32'd0,                                  // Unsigned compare fails
    OPND_A << 4,
    OPND_B >> 4,
    {{4{OPND_B[31]}}, OPND_B[31:4]},        // Arithmetic shift
    32'hABCDE000,
    PRELOAD + 32'h55,
    32'd1,                                  // BEQ skipped the marker
    32'd2,                                  // BNE fell through
    32'h0000_0098,                          // JAL link
    32'h0000_00AC,                          // JALR link
    32'd0                                   // x0 stays zero
};

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    `include "tb_program.svh"

    localparam int TIMEOUT_CYCLES = 2000;   // 49 instr x 12 cycles plus reset with wide margin
    localparam int MEM_WORDS      = 256;    // 0x000 to 0x3FF
    localparam int MAX_WRITES     = 64;

    logic            clk;
    logic            rst_n;
    core_pkg::word_t iwb_adr_o;
    core_pkg::word_t iwb_dat_i;
    logic            iwb_cyc_o;
    logic            iwb_stb_o;
    logic            iwb_ack_i;
    core_pkg::word_t dwb_adr_o;
    core_pkg::word_t dwb_dat_o;
    core_pkg::word_t dwb_dat_i;
    logic            dwb_we_o;
    core_pkg::sel_t  dwb_sel_o;
    logic            dwb_cyc_o;
    logic            dwb_stb_o;
    logic            dwb_ack_i;

    core_pkg::word_t mem [MEM_WORDS];
    core_pkg::word_t wr_adr [MAX_WRITES];   // Captured dwb writes
    core_pkg::word_t wr_dat [MAX_WRITES];
    core_pkg::sel_t  wr_sel [MAX_WRITES];
    int              n_writes  = 0;
    int              seed      = 37;
    int              cycle_cnt = 0;

    rv_core_top rv_core_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .iwb_adr_o (iwb_adr_o),
        .iwb_dat_i (iwb_dat_i),
        .iwb_cyc_o (iwb_cyc_o),
        .iwb_stb_o (iwb_stb_o),
        .iwb_ack_i (iwb_ack_i),
        .dwb_adr_o (dwb_adr_o),
        .dwb_dat_o (dwb_dat_o),
        .dwb_dat_i (dwb_dat_i),
        .dwb_we_o  (dwb_we_o),
        .dwb_sel_o (dwb_sel_o),
        .dwb_cyc_o (dwb_cyc_o),
        .dwb_stb_o (dwb_stb_o),
        .dwb_ack_i (dwb_ack_i)
    );

    task automatic expect_equal(input core_pkg::word_t got, input core_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // ========================================
    // Wishbone memory model
    // ========================================
    initial begin : ibus_model
        int wait_n;
        core_pkg::word_t req_adr;
        forever begin
            @(negedge clk);
            if (iwb_cyc_o && iwb_stb_o) begin
                req_adr = iwb_adr_o;
                // Memory ignores the low bits, so an odd JALR target shows up here
                expect_equal(iwb_adr_o[1:0], 2'b00, "iwb address not word aligned");
                wait_n  = {$random(seed)} % 4;     // 0 to 3 wait states
                repeat (wait_n) @(negedge clk);
                expect_equal(iwb_adr_o, req_adr, "iwb address moved during wait");
                iwb_dat_i = mem[iwb_adr_o[9:2]];
                iwb_ack_i = 1'b1;
                @(negedge clk);
                iwb_ack_i = 1'b0;                  // One cycle ack
            end
        end
    end

    initial begin : dbus_model
        int wait_n;
        core_pkg::word_t req_adr;
        core_pkg::word_t req_dat;
        forever begin
            @(negedge clk);
            if (dwb_cyc_o && dwb_stb_o) begin
                req_adr = dwb_adr_o;
                req_dat = dwb_dat_o;
                wait_n  = {$random(seed)} % 4;
                repeat (wait_n) @(negedge clk);
                expect_equal(dwb_adr_o, req_adr, "dwb address moved during wait");
                expect_equal(dwb_dat_o, req_dat, "dwb write data moved during wait");
                if (dwb_we_o) begin
                    mem[dwb_adr_o[9:2]] = dwb_dat_o;
                    if (n_writes < MAX_WRITES) begin
                        wr_adr[n_writes] = dwb_adr_o;
                        wr_dat[n_writes] = dwb_dat_o;
                        wr_sel[n_writes] = dwb_sel_o;
                    end
                    n_writes++;
                end else begin
                    dwb_dat_i = mem[dwb_adr_o[9:2]];
                end
                dwb_ack_i = 1'b1;
                @(negedge clk);
                dwb_ack_i = 1'b0;
            end
        end
    end

    // Strobes track cyc and we stays inside a data cycle
    always @(negedge clk) begin
        if (rst_n) begin
            expect_equal(iwb_stb_o, iwb_cyc_o, "iwb_stb_o differs from iwb_cyc_o");
            expect_equal(dwb_stb_o, dwb_cyc_o, "dwb_stb_o differs from dwb_cyc_o");
            expect_equal(dwb_we_o && !dwb_cyc_o, 1'b0, "dwb_we_o high outside a cycle");
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the core did not finish its stores within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation timed out");
    end

    // ========================================
    // Stimulus and store checks
    // ========================================
    initial begin : main
        int idx;
        rst_n     = 1'b0;
        iwb_dat_i = '0;
        iwb_ack_i = 1'b0;
        dwb_dat_i = '0;
        dwb_ack_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h0BAD_0000 | (i << 2);   // Unused words tagged with their address
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[i] = program_image[i];
        end
        mem[LOAD_ADDR[9:2]] = PRELOAD;

        repeat (16) @(negedge clk);
        expect_equal(iwb_cyc_o, 1'b0, "iwb_cyc_o high in reset");
        expect_equal(dwb_cyc_o, 1'b0, "dwb_cyc_o high in reset");
        expect_equal(dwb_we_o, 1'b0, "dwb_we_o high in reset");
        rst_n = 1'b1;

        while (!iwb_cyc_o) @(negedge clk);
        expect_equal(iwb_adr_o, core_pkg::RESET_VECTOR, "first fetch address");

        for (idx = 0; idx < STORE_CNT; idx++) begin
            while (n_writes <= idx) @(negedge clk);
            expect_equal(wr_adr[idx], STORE_BASE + 4 * idx, "store address");
            expect_equal(wr_dat[idx], expected_data[idx], "store data");
            expect_equal(wr_sel[idx], core_pkg::SEL_WORD, "store byte select");
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  core_pkg::word_t     op_a_i,
    input  core_pkg::word_t     op_b_i,
    input  rv_isa_pkg::alu_op_t alu_op_i,
    input  rv_isa_pkg::funct3_t funct3_i,
    output core_pkg::word_t     result_o,
    output logic                branch_taken_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = op_b_i[4:0];                     // Low 5 bits only
    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;
    assign eq    = op_a_i == op_b_i;

    // ========================================
    // Arithmetic and logic
    // ========================================
    always_comb begin
        case (alu_op_i)
            rv_isa_pkg::ALU_ADD:    result_o = op_a_i + op_b_i;
            rv_isa_pkg::ALU_SUB:    result_o = op_a_i - op_b_i;
            rv_isa_pkg::ALU_SLL:    result_o = op_a_i << shamt;
            rv_isa_pkg::ALU_SLT:    result_o = {31'b0, lt_s};
            rv_isa_pkg::ALU_SLTU:   result_o = {31'b0, lt_u};
            rv_isa_pkg::ALU_XOR:    result_o = op_a_i ^ op_b_i;
            rv_isa_pkg::ALU_SRL:    result_o = op_a_i >> shamt;
            rv_isa_pkg::ALU_SRA:    result_o = $signed(op_a_i) >>> shamt;
            rv_isa_pkg::ALU_OR:     result_o = op_a_i | op_b_i;
            rv_isa_pkg::ALU_AND:    result_o = op_a_i & op_b_i;
            rv_isa_pkg::ALU_PASS_B: result_o = op_b_i;
            default:                result_o = '0;
        endcase
    end

    // Branch condition, meaningful only for BRANCH
    always_comb begin
        case (funct3_i)
            rv_isa_pkg::F3_BEQ:  branch_taken_o = eq;
            rv_isa_pkg::F3_BNE:  branch_taken_o = !eq;
            rv_isa_pkg::F3_BLT:  branch_taken_o = lt_s;
            rv_isa_pkg::F3_BGE:  branch_taken_o = !lt_s;
            rv_isa_pkg::F3_BLTU: branch_taken_o = lt_u;
            rv_isa_pkg::F3_BGEU: branch_taken_o = !lt_u;
            default:             branch_taken_o = 1'b0;   // Reserved codes
        endcase
    end

endmodule

/* verilog/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    decode_if.ctrl             dec,
    input  core_pkg::word_t    rs1_data_i,
    input  core_pkg::word_t    rs2_data_i,
    input  core_pkg::word_t    alu_result_i,
    input  logic               branch_taken_i,
    output core_pkg::word_t    instr_o,
    output core_pkg::word_t    op_a_o,
    output core_pkg::word_t    op_b_o,
    output core_pkg::reg_idx_t rd_idx_o,
    output core_pkg::word_t    rd_data_o,
    output logic               rd_wen_o,

    // Instruction bus
    output core_pkg::word_t    iwb_adr_o,
    input  core_pkg::word_t    iwb_dat_i,
    output logic               iwb_cyc_o,
    output logic               iwb_stb_o,
    input  logic               iwb_ack_i,

    // Data bus
    output core_pkg::word_t    dwb_adr_o,
    output core_pkg::word_t    dwb_dat_o,
    input  core_pkg::word_t    dwb_dat_i,
    output logic               dwb_we_o,
    output core_pkg::sel_t     dwb_sel_o,
    output logic               dwb_cyc_o,
    output logic               dwb_stb_o,
    input  logic               dwb_ack_i
);

    core_pkg::ctrl_state_e state_q;
    core_pkg::word_t       pc_q;
    core_pkg::word_t       instr_q;
    core_pkg::word_t       alu_q;      // Registered ALU result
    core_pkg::word_t       load_q;     // Latched read data
    logic                  taken_q;
    logic                  iwb_cyc_q;
    logic                  dwb_cyc_q;
    logic                  dwb_we_q;
    core_pkg::word_t       pc_plus4;
    core_pkg::word_t       pc_next;

    // ========================================
    // Operand select and writeback
    // ========================================
    assign op_a_o = dec.src_a_pc   ? pc_q :
                    dec.src_a_zero ? '0   : rs1_data_i;
    assign op_b_o = dec.src_b_imm  ? dec.imm : rs2_data_i;

    assign pc_plus4  = pc_q + core_pkg::PC_STEP;
    assign instr_o   = instr_q;
    assign rd_idx_o  = dec.rd;
    assign rd_wen_o  = dec.reg_write && (state_q == core_pkg::ST_WRITEBACK);
    assign rd_data_o = dec.mem_read                ? load_q   :
                       (dec.is_jal || dec.is_jalr) ? pc_plus4 :   // Link address
                                                     alu_q;

    always_comb begin
        pc_next = pc_plus4;
        if (dec.is_jal || (dec.is_branch && taken_q)) begin
            pc_next = pc_q + dec.imm;
        end else if (dec.is_jalr) begin
            pc_next = {alu_q[core_pkg::XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared
        end
    end

    // Bus outputs held steady while waiting for ack
    assign iwb_adr_o = pc_q;
    assign iwb_cyc_o = iwb_cyc_q;
    assign iwb_stb_o = iwb_cyc_q;
    assign dwb_adr_o = alu_q;
    assign dwb_dat_o = rs2_data_i;
    assign dwb_we_o  = dwb_we_q;
    assign dwb_sel_o = core_pkg::SEL_WORD;     // Word access only
    assign dwb_cyc_o = dwb_cyc_q;
    assign dwb_stb_o = dwb_cyc_q;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= core_pkg::ST_FETCH;
            pc_q      <= core_pkg::RESET_VECTOR;
            iwb_cyc_q <= 1'b0;
            dwb_cyc_q <= 1'b0;
            dwb_we_q  <= 1'b0;
        end else begin
            case (state_q)
                core_pkg::ST_FETCH: begin
                    if (iwb_cyc_q && iwb_ack_i) begin
                        iwb_cyc_q <= 1'b0;
                        state_q   <= core_pkg::ST_EXECUTE;
                    end else begin
                        iwb_cyc_q <= 1'b1;       // First request after reset
                    end
                end
                core_pkg::ST_EXECUTE: begin
                    if (dec.mem_read || dec.mem_write) begin
                        dwb_cyc_q <= 1'b1;       // Raised on entry to MEM
                        dwb_we_q  <= dec.mem_write;
                        state_q   <= core_pkg::ST_MEM;
                    end else begin
                        state_q   <= core_pkg::ST_WRITEBACK;
                    end
                end
                core_pkg::ST_MEM: begin
                    if (dwb_ack_i) begin
                        dwb_cyc_q <= 1'b0;
                        dwb_we_q  <= 1'b0;
                        state_q   <= core_pkg::ST_WRITEBACK;
                    end
                end
                core_pkg::ST_WRITEBACK: begin
                    pc_q      <= pc_next;
                    iwb_cyc_q <= 1'b1;           // Next fetch on following cycle
                    state_q   <= core_pkg::ST_FETCH;
                end
                default: state_q <= core_pkg::ST_FETCH;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state_q == core_pkg::ST_FETCH && iwb_cyc_q && iwb_ack_i) begin
            instr_q <= iwb_dat_i;
        end
        if (state_q == core_pkg::ST_EXECUTE) begin
            alu_q   <= alu_result_i;
            taken_q <= branch_taken_i;
        end
        if (state_q == core_pkg::ST_MEM && dwb_ack_i) begin
            load_q  <= dwb_dat_i;
        end
    end

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

    // ========================================
    // Datapath widths
    // ========================================
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      sel_t;      // Wishbone byte lanes

    localparam sel_t SEL_WORD = 4'b1111;

    // Program counter
    localparam word_t RESET_VECTOR = 32'h0000_0000;
    localparam word_t PC_STEP      = 32'd4;

    // Control FSM, one instruction at a time
    typedef enum logic [1:0] {
        ST_FETCH,       // Wait for iwb ack
        ST_EXECUTE,     // Register ALU result
        ST_MEM,         // Wait for dwb ack
        ST_WRITEBACK    // Regfile write, PC update
    } ctrl_state_e;

endpackage

/* verilog/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;

    core_pkg::reg_idx_t  rs1;
    core_pkg::reg_idx_t  rs2;
    core_pkg::reg_idx_t  rd;
    core_pkg::word_t     imm;          // Sign extended immediate
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::alu_op_t alu_op;
    logic                src_b_imm;    // B from imm, else rs2
    logic                src_a_pc;     // A from PC (AUIPC)
    logic                src_a_zero;   // A forced to 0
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;

    modport dec (output rs1, rs2, rd, imm, funct3, alu_op, src_b_imm, src_a_pc,
                 src_a_zero, reg_write, mem_read, mem_write, is_branch, is_jal, is_jalr);

    modport ctrl (input rd, imm, src_b_imm, src_a_pc, src_a_zero, reg_write,
                  mem_read, mem_write, is_branch, is_jal, is_jalr);

    // Source indices only
    modport rf (input rs1, rs2);

endinterface

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  core_pkg::word_t instr_i,
    decode_if.dec           dec
);

    rv_isa_pkg::opcode_t opcode;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_s;
    core_pkg::word_t     imm_b;
    core_pkg::word_t     imm_u;
    core_pkg::word_t     imm_j;

    // funct3 plus funct7 bit 5 to ALU operation
    function automatic rv_isa_pkg::alu_op_t alu_sel(input rv_isa_pkg::funct3_t f3,
                                                     input logic alt);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: alu_sel = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_sel = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_sel = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_sel = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_sel = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_sel = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_sel = rv_isa_pkg::ALU_OR;
            default:                alu_sel = rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr_i[6:0];

    // ========================================
    // Immediate formats
    // ========================================
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // Register fields always passed through
    assign dec.rs1    = instr_i[19:15];
    assign dec.rs2    = instr_i[24:20];
    assign dec.rd     = instr_i[11:7];
    assign dec.funct3 = instr_i[14:12];

    always_comb begin
        // Unknown opcode retires as a no-op
        dec.imm        = '0;
        dec.alu_op     = rv_isa_pkg::ALU_ADD;
        dec.src_b_imm  = 1'b0;
        dec.src_a_pc   = 1'b0;
        dec.src_a_zero = 1'b0;
        dec.reg_write  = 1'b0;
        dec.mem_read   = 1'b0;
        dec.mem_write  = 1'b0;
        dec.is_branch  = 1'b0;
        dec.is_jal     = 1'b0;
        dec.is_jalr    = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.alu_op    = alu_sel(instr_i[14:12], instr_i[30]);
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // Bit 30 selects SRAI only, ADDI has no SUB form
                dec.alu_op    = alu_sel(instr_i[14:12],
                                        instr_i[30] && (instr_i[14:12] == rv_isa_pkg::F3_SRL_SRA));
                dec.imm       = imm_i;
                dec.src_b_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                dec.alu_op     = rv_isa_pkg::ALU_PASS_B;
                dec.imm        = imm_u;
                dec.src_b_imm  = 1'b1;
                dec.src_a_zero = 1'b1;
                dec.reg_write  = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                dec.imm       = imm_u;
                dec.src_b_imm = 1'b1;
                dec.src_a_pc  = 1'b1;      // PC + imm
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;     // rs1 vs rs2 in ALU compare
                dec.is_branch = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                dec.imm       = imm_i;     // Target is rs1 + imm
                dec.src_b_imm = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_LOAD: begin
                dec.imm       = imm_i;
                dec.src_b_imm = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                dec.imm       = imm_s;
                dec.src_b_imm = 1'b1;
                dec.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    decode_if.rf               rf,
    input  core_pkg::reg_idx_t rd_idx_i,
    input  core_pkg::word_t    rd_data_i,
    input  logic               rd_wen_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o
);

    // x1 to x31, no storage behind x0
    core_pkg::word_t regs_q [1:core_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rd_wen_i && (rd_idx_i != '0)) begin
            regs_q[rd_idx_i] <= rd_data_i;   // x0 writes dropped
        end
    end

    // Combinational read ports
    assign rs1_data_o = (rf.rs1 == '0) ? '0 : regs_q[rf.rs1];
    assign rs2_data_o = (rf.rs2 == '0) ? '0 : regs_q[rf.rs2];

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic            clk,
    input  logic            rst_n,

    // Instruction bus master
    output core_pkg::word_t iwb_adr_o,
    input  core_pkg::word_t iwb_dat_i,
    output logic            iwb_cyc_o,
    output logic            iwb_stb_o,
    input  logic            iwb_ack_i,

    // Data bus master
    output core_pkg::word_t dwb_adr_o,
    output core_pkg::word_t dwb_dat_o,
    input  core_pkg::word_t dwb_dat_i,
    output logic            dwb_we_o,
    output core_pkg::sel_t  dwb_sel_o,
    output logic            dwb_cyc_o,
    output logic            dwb_stb_o,
    input  logic            dwb_ack_i
);

    core_pkg::word_t    instr;
    core_pkg::word_t    rs1_data;
    core_pkg::word_t    rs2_data;
    core_pkg::word_t    op_a;
    core_pkg::word_t    op_b;
    core_pkg::word_t    alu_result;
    logic               branch_taken;
    core_pkg::reg_idx_t rd_idx;
    core_pkg::word_t    rd_data;
    logic               rd_wen;

    decode_if dec_bus ();   // Decoded control bundle

    decoder decoder_inst (
        .instr_i (instr),
        .dec     (dec_bus)
    );

    regfile regfile_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rf         (dec_bus),
        .rd_idx_i   (rd_idx),
        .rd_data_i  (rd_data),
        .rd_wen_i   (rd_wen),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Op and condition straight from the decoder
    alu alu_inst (
        .op_a_i         (op_a),
        .op_b_i         (op_b),
        .alu_op_i       (dec_bus.alu_op),
        .funct3_i       (dec_bus.funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    core_ctrl core_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec            (dec_bus),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .alu_result_i   (alu_result),
        .branch_taken_i (branch_taken),
        .instr_o        (instr),
        .op_a_o         (op_a),
        .op_b_o         (op_b),
        .rd_idx_o       (rd_idx),
        .rd_data_o      (rd_data),
        .rd_wen_o       (rd_wen),
        .iwb_adr_o      (iwb_adr_o),
        .iwb_dat_i      (iwb_dat_i),
        .iwb_cyc_o      (iwb_cyc_o),
        .iwb_stb_o      (iwb_stb_o),
        .iwb_ack_i      (iwb_ack_i),
        .dwb_adr_o      (dwb_adr_o),
        .dwb_dat_o      (dwb_dat_o),
        .dwb_dat_i      (dwb_dat_i),
        .dwb_we_o       (dwb_we_o),
        .dwb_sel_o      (dwb_sel_o),
        .dwb_cyc_o      (dwb_cyc_o),
        .dwb_stb_o      (dwb_stb_o),
        .dwb_ack_i      (dwb_ack_i)
    );

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ========================================
    // Major opcodes
    // ========================================
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // Minor codes
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_BEQ  = 3'b000;   // Branch conditions
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_ADD_SUB = 3'b000;   // OP and OP-IMM
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // ALU operations
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

endpackage
